// File: design/rv_core_pkg.sv
package rv_core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,  // signed compare
    ALU_SLTU   = 4'd4,  // unsigned compare
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,  // arithmetic shift
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_t;

  // operand b source
  typedef enum logic {
    SRC_B_REG = 1'b0,
    SRC_B_IMM = 1'b1
  } src_b_t;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

// File: design/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                arst_n,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_rdata,
  output logic                retire_valid,
  output logic [`RV_XLEN-1:0] retire_pc,
  output logic [4:0]          retire_rd,
  output logic [`RV_XLEN-1:0] retire_wd,
  output logic                retire_wen,
  output logic                retire_illegal,
  output logic                halted
);

  import rv_core_pkg::*;

  logic                fetch_valid;
  logic [`RV_XLEN-1:0] fetch_pc;
  logic [31:0]         fetch_instr;
  logic [4:0]          rs1_addr;
  logic [4:0]          rs2_addr;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                dec_valid;
  logic [`RV_XLEN-1:0] dec_pc;
  alu_op_t             dec_op;
  logic [`RV_XLEN-1:0] dec_a;
  logic [`RV_XLEN-1:0] dec_b;
  logic [4:0]          dec_rd;
  logic                dec_wen;
  logic                dec_illegal;
  logic                dec_halt;
  logic                wb_en;
  logic [4:0]          wb_addr;
  logic [`RV_XLEN-1:0] wb_data;

  rv_fetch u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .halted       (halted),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr)
  );

  rv_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .dec_valid   (dec_valid),
    .dec_pc      (dec_pc),
    .dec_op      (dec_op),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_rd      (dec_rd),
    .dec_wen     (dec_wen),
    .dec_illegal (dec_illegal),
    .dec_halt    (dec_halt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  rv_exec u_exec (
    .clk            (clk),
    .arst_n         (arst_n),
    .dec_valid      (dec_valid),
    .dec_pc         (dec_pc),
    .dec_op         (dec_op),
    .dec_a          (dec_a),
    .dec_b          (dec_b),
    .dec_rd         (dec_rd),
    .dec_wen        (dec_wen),
    .dec_illegal    (dec_illegal),
    .dec_halt       (dec_halt),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_wd      (retire_wd),
    .retire_wen     (retire_wen),
    .retire_illegal (retire_illegal),
    .halted         (halted)
  );

endmodule

// File: design/rv_decode.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 fetch_valid,
  input  logic [`RV_XLEN-1:0]  fetch_pc,
  input  logic [31:0]          fetch_instr,
  output logic [4:0]           rs1_addr,
  output logic [4:0]           rs2_addr,
  input  logic [`RV_XLEN-1:0]  rs1_data,
  input  logic [`RV_XLEN-1:0]  rs2_data,
  output logic                 dec_valid,
  output logic [`RV_XLEN-1:0]  dec_pc,
  output rv_core_pkg::alu_op_t dec_op,
  output logic [`RV_XLEN-1:0]  dec_a,
  output logic [`RV_XLEN-1:0]  dec_b,
  output logic [4:0]           dec_rd,
  output logic                 dec_wen,
  output logic                 dec_illegal,
  output logic                 dec_halt
);

  import rv_core_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [4:0]          rd;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm;
  alu_op_t             op;
  src_b_t              b_sel;
  logic                wen;
  logic                illegal;
  logic                halt;

  assign opcode   = fetch_instr[6:0];
  assign rd       = fetch_instr[11:7];
  assign funct3   = fetch_instr[14:12];
  assign funct7   = fetch_instr[31:25];
  assign rs1_addr = fetch_instr[19:15];
  assign rs2_addr = fetch_instr[24:20];

  assign imm_i = {{(`RV_XLEN-12){fetch_instr[31]}}, fetch_instr[31:20]};
  assign imm_u = {fetch_instr[31:12], 12'b0};

  always_comb begin
    op      = ALU_ADD;
    b_sel   = SRC_B_REG;
    imm     = imm_i;
    wen     = 1'b0;
    illegal = 1'b0;
    halt    = 1'b0;
    case (opcode)
      OPC_OP: begin
        wen = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: op = ALU_ADD;
          {7'h20, 3'b000}: op = ALU_SUB;
          {7'h00, 3'b001}: op = ALU_SLL;
          {7'h00, 3'b010}: op = ALU_SLT;
          {7'h00, 3'b011}: op = ALU_SLTU;
          {7'h00, 3'b100}: op = ALU_XOR;
          {7'h00, 3'b101}: op = ALU_SRL;
          {7'h20, 3'b101}: op = ALU_SRA;
          {7'h00, 3'b110}: op = ALU_OR;
          {7'h00, 3'b111}: op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        wen   = 1'b1;
        b_sel = SRC_B_IMM;
        case (funct3)
          3'b000: op = ALU_ADD;
          3'b010: op = ALU_SLT;
          3'b011: op = ALU_SLTU;
          3'b100: op = ALU_XOR;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          3'b001: begin
            op      = ALU_SLL;
            illegal = (funct7 != 7'h00);
          end
          default: begin  // srli / srai
            op      = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPC_LUI: begin
        wen   = 1'b1;
        op    = ALU_PASS_B;
        b_sel = SRC_B_IMM;
        imm   = imm_u;
      end
      OPC_SYSTEM: begin
        halt    = (fetch_instr == EBREAK_WORD);
        illegal = !halt;  // ecall and csr ops not handled
      end
      default: illegal = 1'b1;
    endcase
    if (illegal || rd == 5'd0) wen = 1'b0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) dec_valid <= 1'b0;
    else         dec_valid <= fetch_valid;
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      dec_pc      <= fetch_pc;
      dec_op      <= op;
      dec_a       <= rs1_data;
      dec_b       <= (b_sel == SRC_B_IMM) ? imm : rs2_data;
      dec_rd      <= rd;
      dec_wen     <= wen;
      dec_illegal <= illegal;
      dec_halt    <= halt;
    end
  end

endmodule

// File: design/rv_exec.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_exec (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 dec_valid,
  input  logic [`RV_XLEN-1:0]  dec_pc,
  input  rv_core_pkg::alu_op_t dec_op,
  input  logic [`RV_XLEN-1:0]  dec_a,
  input  logic [`RV_XLEN-1:0]  dec_b,
  input  logic [4:0]           dec_rd,
  input  logic                 dec_wen,
  input  logic                 dec_illegal,
  input  logic                 dec_halt,
  output logic                 wb_en,
  output logic [4:0]           wb_addr,
  output logic [`RV_XLEN-1:0]  wb_data,
  output logic                 retire_valid,
  output logic [`RV_XLEN-1:0]  retire_pc,
  output logic [4:0]           retire_rd,
  output logic [`RV_XLEN-1:0]  retire_wd,
  output logic                 retire_wen,
  output logic                 retire_illegal,
  output logic                 halted
);

  import rv_core_pkg::*;

  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] alu_res;
  logic                retire_halt;
  logic                halt_q;

  assign shamt = dec_b[4:0];

  always_comb begin
    case (dec_op)
      ALU_ADD:    alu_res = dec_a + dec_b;
      ALU_SUB:    alu_res = dec_a - dec_b;
      ALU_SLL:    alu_res = dec_a << shamt;
      ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(dec_a) < $signed(dec_b)};
      ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, dec_a < dec_b};
      ALU_XOR:    alu_res = dec_a ^ dec_b;
      ALU_SRL:    alu_res = dec_a >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(dec_a) >>> shamt);
      ALU_OR:     alu_res = dec_a | dec_b;
      ALU_AND:    alu_res = dec_a & dec_b;
      ALU_PASS_B: alu_res = dec_b;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
      if (retire_valid && retire_halt) halt_q <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire_pc      <= dec_pc;
      retire_rd      <= dec_rd;
      retire_wd      <= alu_res;
      retire_wen     <= dec_wen;
      retire_illegal <= dec_illegal;
      retire_halt    <= dec_halt;
    end
  end

  assign wb_en   = retire_valid && retire_wen;
  assign wb_addr = retire_rd;
  assign wb_data = retire_wd;

  // rises with the ebreak retire itself
  assign halted = halt_q || (retire_valid && retire_halt);

  a_retire_gap: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |=> !retire_valid);

  a_no_retire_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
    halt_q |-> !retire_valid);

endmodule

// File: design/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                retire_valid,
  input  logic                halted,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_rdata,
  output logic                fetch_valid,
  output logic [`RV_XLEN-1:0] fetch_pc,
  output logic [31:0]         fetch_instr
);

  localparam logic [`RV_XLEN-1:0] PC_STEP = 4;

  typedef enum logic {
    S_IDLE = 1'b0,
    S_WAIT = 1'b1
  } state_t;

  state_t              state;
  logic [`RV_XLEN-1:0] pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        S_IDLE: if (!halted) state <= S_WAIT;
        S_WAIT: begin
          if (retire_valid) begin  // previous instr done
            state <= S_IDLE;
            pc    <= pc + PC_STEP;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign imem_addr   = pc;
  assign fetch_valid = (state == S_IDLE) && !halted;
  assign fetch_pc    = pc;
  assign fetch_instr = imem_rdata;  // memory answers same cycle

  // one instruction in flight until it retires
  a_one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
    fetch_valid |=> (!fetch_valid throughout retire_valid [->1]));

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [4:0]          rs1_addr,
  input  logic [4:0]          rs2_addr,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                wb_en,
  input  logic [4:0]          wb_addr,
  input  logic [`RV_XLEN-1:0] wb_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != 5'd0) begin  // x0 stays zero
      regs[wb_addr] <= wb_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define RV_XLEN 32

// first fetch address
`define RV_RESET_PC 32'h8000_0000

// architectural integer registers
`define RV_NREGS 32

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb \
  -f rv_core.f -Mdir obj_dir -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// File: rv_core.f
+incdir+include
design/rv_core_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_exec.sv
design/rv_core_top.sv
sim/rv_core_tb.sv

// File: sim/rv_core_stim.txt
// words 0 and 1: program length and record count
// then one program word per line, then one retire record per line
// record columns: pc rd value wen illegal (value unused when wen is 0)
0000001c
0000001c
f0f0f0b7 // lui   x1, 0xf0f0f
ff008093 // addi  x1, x1, -16
12345137 // lui   x2, 0x12345
67810113 // addi  x2, x2, 0x678
002081b3 // add   x3, x1, x2
40208233 // sub   x4, x1, x2
0020a2b3 // slt   x5, x1, x2
0020b333 // sltu  x6, x1, x2
0020c3b3 // xor   x7, x1, x2
0020e433 // or    x8, x1, x2
0020f4b3 // and   x9, x1, x2
00209533 // sll   x10, x1, x2
0020d5b3 // srl   x11, x1, x2
4020d633 // sra   x12, x1, x2
fff0a693 // slti  x13, x1, -1
fff13713 // sltiu x14, x2, -1
fff14793 // xori  x15, x2, -1
80016813 // ori   x16, x2, -2048
7ff0f893 // andi  x17, x1, 0x7ff
00411913 // slli  x18, x2, 4
01f0d993 // srli  x19, x1, 31
4080da13 // srai  x20, x1, 8
abcdeab7 // lui   x21, 0xabcde
00508013 // addi  x0, x1, 5
00100b33 // add   x22, x0, x1
022081b3 // mul   x3, x1, x2 (not supported)
00018b93 // addi  x23, x3, 0
00100073 // ebreak
80000000 01 f0f0f000 1 0
80000004 01 f0f0eff0 1 0
80000008 02 12345000 1 0
8000000c 02 12345678 1 0
80000010 03 03254668 1 0
80000014 04 debc9978 1 0
80000018 05 00000001 1 0
8000001c 06 00000000 1 0
80000020 07 e2c4b988 1 0
80000024 08 f2f4fff8 1 0
80000028 09 10304670 1 0
8000002c 0a f0000000 1 0
80000030 0b 000000f0 1 0
80000034 0c fffffff0 1 0
80000038 0d 00000001 1 0
8000003c 0e 00000001 1 0
80000040 0f edcba987 1 0
80000044 10 fffffe78 1 0
80000048 11 000007f0 1 0
8000004c 12 23456780 1 0
80000050 13 00000001 1 0
80000054 14 fff0f0ef 1 0
80000058 15 abcde000 1 0
8000005c 00 00000000 0 0
80000060 16 f0f0eff0 1 0
80000064 03 00000000 0 1
80000068 17 03254668 1 0
8000006c 00 00000000 0 0

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;

  localparam int STIM_DEPTH       = 512;
  localparam int PROG_BASE        = 2;  // words 0 and 1 hold the counts
  localparam int REC_FIELDS       = 5;
  localparam int RESET_CYCLES     = 4;
  localparam int RETIRE_GAP       = 3;
  localparam int POST_HALT_CYCLES = 20;

  logic                clk;
  logic                arst_n;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic                retire_valid;
  logic [`RV_XLEN-1:0] retire_pc;
  logic [4:0]          retire_rd;
  logic [`RV_XLEN-1:0] retire_wd;
  logic                retire_wen;
  logic                retire_illegal;
  logic                halted;

  logic [31:0] stim_mem [STIM_DEPTH];
  int          prog_len;
  int          rec_count;
  int          word_index;
  int          cycle_count;
  int          timeout_limit;
  int          last_retire_cycle;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  rv_core_top uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .imem_addr      (imem_addr),
    .imem_rdata     (imem_rdata),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_wd      (retire_wd),
    .retire_wen     (retire_wen),
    .retire_illegal (retire_illegal),
    .halted         (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // instruction memory, answers in the same cycle
  always_comb begin
    word_index = int'((imem_addr - `RV_RESET_PC) >> 2);
    if (imem_addr[1:0] == 2'b00 && word_index < prog_len) begin
      imem_rdata = stim_mem[PROG_BASE + word_index];
    end else begin
      imem_rdata = ~imem_addr;  // outside the program
    end
  end

  always @(posedge clk) begin
    if (!arst_n) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > timeout_limit) begin
        $display("timeout: the run did not end within %0d cycles", timeout_limit);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  task automatic check_word(input string name, input logic [`RV_XLEN-1:0] expected,
                            input logic [`RV_XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic wait_retire();
    do begin
      @(negedge clk);  // outputs settled mid cycle
    end while (!retire_valid);
  endtask

  task automatic run_record(input int idx);
    int          base;
    int          start_errors;
    logic [31:0] exp_pc;
    logic [31:0] exp_rd;
    logic [31:0] exp_wd;
    logic        exp_wen;
    logic        exp_illegal;
    logic        exp_halt;
    base         = PROG_BASE + prog_len + idx * REC_FIELDS;
    exp_pc       = stim_mem[base];
    exp_rd       = stim_mem[base + 1];
    exp_wd       = stim_mem[base + 2];
    exp_wen      = stim_mem[base + 3][0];
    exp_illegal  = stim_mem[base + 4][0];
    exp_halt     = (idx == rec_count - 1);  // program ends with ebreak
    start_errors = error_count;
    wait_retire();
    if (idx > 0) begin
      check_word($sformatf("record %0d retire gap", idx), RETIRE_GAP,
                 cycle_count - last_retire_cycle);
    end
    last_retire_cycle = cycle_count;
    check_word($sformatf("record %0d pc", idx), exp_pc, retire_pc);
    check_word($sformatf("record %0d rd", idx), exp_rd,
               {{(`RV_XLEN-5){1'b0}}, retire_rd});
    if (exp_wen) begin
      check_word($sformatf("record %0d write data", idx), exp_wd, retire_wd);
    end
    check_flag($sformatf("record %0d wen", idx), exp_wen, retire_wen);
    check_flag($sformatf("record %0d illegal", idx), exp_illegal, retire_illegal);
    check_flag($sformatf("record %0d halted", idx), exp_halt, halted);
    tests_run++;
    if (error_count == start_errors) begin
      $display("record %0d pc %h: ok", idx, exp_pc);
    end else begin
      tests_failed++;
      $display("record %0d pc %h: failed", idx, exp_pc);
    end
  endtask

  // nothing may retire once the core has halted
  task automatic watch_halt();
    int start_errors;
    start_errors = error_count;
    repeat (POST_HALT_CYCLES) begin
      @(negedge clk);
      if (retire_valid) begin
        $display("retire_valid seen after the halt, pc %h", retire_pc);
        error_count++;
      end
      if (!halted) begin
        $display("halted dropped after the ebreak retired");
        error_count++;
      end
    end
    tests_run++;
    if (error_count == start_errors) begin
      $display("halt window of %0d cycles: ok", POST_HALT_CYCLES);
    end else begin
      tests_failed++;
      $display("halt window of %0d cycles: failed", POST_HALT_CYCLES);
    end
  endtask

  initial begin
    arst_n            = 1'b0;
    last_retire_cycle = 0;
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    $readmemh("sim/rv_core_stim.txt", stim_mem);
    prog_len      = int'(stim_mem[0]);
    rec_count     = int'(stim_mem[1]);
    timeout_limit = RETIRE_GAP * rec_count + POST_HALT_CYCLES;
    if (prog_len < 1 || rec_count != prog_len ||
        PROG_BASE + prog_len + rec_count * REC_FIELDS > STIM_DEPTH) begin
      $display("stimulus file layout does not fit the memory model");
      error_count++;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < rec_count; i++) begin
        run_record(i);
      end
      watch_halt();
    end
    $display("%0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
